// File: include/c2a_cfg.svh
// configuration macros for the core to AXI subsystem
// address width, AXI data and ID widths, memory model size

`ifndef C2A_CFG_SVH
`define C2A_CFG_SVH

// ------------------------------
// bus widths
// ------------------------------

// byte address width, same on core and AXI side
`define C2A_ADDR_WIDTH 32

// shared AXI data bus, 64 or 32 bits
`define C2A_AXI_DATA_WIDTH 64

// id width on the shared port
// msb carries the index of the issuing port
`define C2A_AXI_ID_WIDTH 4

// ------------------------------
// memory model
// ------------------------------
// addresses at or above this size answer with an error
`define C2A_MEM_BYTES 4096

`endif

// File: src/c2a_pkg.sv
// shared types for the core to AXI subsystem
// width typedefs, core request/response structs
// single-beat AXI channel structs and response codes
// bridge FSM state encoding

`include "c2a_cfg.svh"

package c2a_pkg;

  // ------------------------------
  // vector types
  // ------------------------------
  typedef logic [`C2A_ADDR_WIDTH-1:0]       addr_t;
  typedef logic [31:0]                      word_t;
  typedef logic [3:0]                       be_t;
  typedef logic [`C2A_AXI_DATA_WIDTH-1:0]   axi_data_t;
  typedef logic [`C2A_AXI_DATA_WIDTH/8-1:0] axi_strb_t;
  typedef logic [`C2A_AXI_ID_WIDTH-1:0]     axi_id_t;
  typedef logic [1:0]                       axi_resp_t;

  // axi response codes
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_EXOKAY = 2'b01;
  localparam axi_resp_t RESP_SLVERR = 2'b10;
  localparam axi_resp_t RESP_DECERR = 2'b11;

  // axsize for a 4-byte core word
  localparam logic [2:0] AXI_SIZE_WORD = 3'b010;

  // ------------------------------
  // core port
  // ------------------------------
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    word_t wdata;
  } core_req_t;

  // err set when the AXI response was not OKAY
  typedef struct packed {
    word_t rdata;
    logic  err;
  } core_rsp_t;

  // ------------------------------
  // axi channels, single beat only
  // ------------------------------
  typedef struct packed {
    axi_id_t    id;
    addr_t      addr;
    logic [2:0] size;
  } axi_aw_t;

  typedef struct packed {
    axi_id_t    id;
    addr_t      addr;
    logic [2:0] size;
  } axi_ar_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

  // bridge FSM
  typedef enum logic [2:0] {
    BR_IDLE,
    BR_READ_WAIT,
    BR_WRITE_DATA,
    BR_WRITE_ADDR,
    BR_WRITE_WAIT
  } bridge_state_e;

endpackage

// File: src/core2axi_bridge.sv
// core memory port to single-beat AXI4 bridge
// request/grant/rvalid on the core side, valid/ready on AXI
// FSM issuing AW and W together, either may be accepted first
// read lane select, write data replication and strobe placement
// error flag beside rvalid for non-OKAY responses

`timescale 1ns/10ps

`include "c2a_cfg.svh"

module core2axi_bridge
  import c2a_pkg::*;
#(
  // id put on every AW and AR of this port
  parameter axi_id_t AXI_ID = '0
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // core side
  input  logic      req_i,
  input  core_req_t core_req_i,
  output logic      gnt_o,
  output logic      rvalid_o,
  output core_rsp_t core_rsp_o,
  // axi write address
  output axi_aw_t   aw_o,
  output logic      aw_valid_o,
  input  logic      aw_ready_i,
  // axi write data
  output axi_w_t    w_o,
  output logic      w_valid_o,
  input  logic      w_ready_i,
  // axi write response
  input  axi_b_t    b_i,
  input  logic      b_valid_i,
  output logic      b_ready_o,
  // axi read address
  output axi_ar_t   ar_o,
  output logic      ar_valid_o,
  input  logic      ar_ready_i,
  // axi read data
  input  axi_r_t    r_i,
  input  logic      r_valid_i,
  output logic      r_ready_o
);

  localparam int unsigned AXI_DW = `C2A_AXI_DATA_WIDTH;
  // number of 32-bit lanes on the AXI data bus
  localparam int unsigned LANES  = AXI_DW / 32;

  bridge_state_e state_q, state_d;

  word_t     rdata;
  axi_strb_t w_strb;
  logic      resp_err;

  // ------------------------------
  // main FSM
  // ------------------------------
  always_comb begin
    state_d    = state_q;
    gnt_o      = 1'b0;
    rvalid_o   = 1'b0;
    aw_valid_o = 1'b0;
    w_valid_o  = 1'b0;
    ar_valid_o = 1'b0;
    b_ready_o  = 1'b0;
    r_ready_o  = 1'b0;

    case (state_q)
      // wait for a core request
      BR_IDLE: begin
        if (req_i) begin
          if (core_req_i.we) begin
            // address and data go out in the same cycle
            aw_valid_o = 1'b1;
            w_valid_o  = 1'b1;
            if (aw_ready_i && w_ready_i) begin
              gnt_o   = 1'b1;
              state_d = BR_WRITE_WAIT;
            end else if (aw_ready_i) begin
              state_d = BR_WRITE_DATA;
            end else if (w_ready_i) begin
              state_d = BR_WRITE_ADDR;
            end
          end else begin
            ar_valid_o = 1'b1;
            if (ar_ready_i) begin
              gnt_o   = 1'b1;
              state_d = BR_READ_WAIT;
            end
          end
        end
      end

      // address taken, data still pending
      BR_WRITE_DATA: begin
        w_valid_o = 1'b1;
        if (w_ready_i) begin
          gnt_o   = 1'b1;
          state_d = BR_WRITE_WAIT;
        end
      end

      // data taken first, address still pending
      BR_WRITE_ADDR: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          gnt_o   = 1'b1;
          state_d = BR_WRITE_WAIT;
        end
      end

      // write fully issued, wait for B
      BR_WRITE_WAIT: begin
        b_ready_o = 1'b1;
        if (b_valid_i) begin
          rvalid_o = 1'b1;
          state_d  = BR_IDLE;
        end
      end

      // read issued, wait for the single R beat
      BR_READ_WAIT: begin
        r_ready_o = 1'b1;
        if (r_valid_i) begin
          rvalid_o = 1'b1;
          state_d  = BR_IDLE;
        end
      end

      default: begin
        state_d = BR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= BR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------
  // data lane handling
  // ------------------------------
  if (AXI_DW == 32) begin : g_lane_32
    // bus and core word line up directly
    assign rdata  = r_i.data[31:0];
    assign w_strb = core_req_i.be;
  end else begin : g_lane_64
    logic lane_q;

    // word half of the request, sampled when the address goes out
    always_ff @(posedge clk_i) begin
      if (gnt_o) begin
        lane_q <= core_req_i.addr[2];
      end
    end

    assign rdata  = lane_q ? r_i.data[63:32] : r_i.data[31:0];
    // strobes only on the half addressed by bit 2
    assign w_strb = core_req_i.addr[2] ? {core_req_i.be, 4'b0000}
                                       : {4'b0000, core_req_i.be};
  end

  // response code of whichever channel is completing
  assign resp_err = (state_q == BR_WRITE_WAIT) ? (b_i.resp != RESP_OKAY)
                                               : (r_i.resp != RESP_OKAY);

  assign core_rsp_o = '{rdata: rdata, err: resp_err};

  // ------------------------------
  // axi payloads
  // ------------------------------
  assign aw_o = '{id: AXI_ID, addr: core_req_i.addr, size: AXI_SIZE_WORD};
  assign ar_o = '{id: AXI_ID, addr: core_req_i.addr, size: AXI_SIZE_WORD};
  // write word copied onto every lane, strobes pick the live one
  assign w_o  = '{data: {LANES{core_req_i.wdata}}, strb: w_strb, last: 1'b1};

endmodule

// File: src/axi_port_arbiter.sv
// two-master to one-port AXI arbiter, single beat, no register stage
// round-robin read choice, held from valid until AR handshake
// round-robin write choice, locked until both AW and W have passed
// id msb tagged with the master index, B and R routed back by it

`timescale 1ns/10ps

`include "c2a_cfg.svh"

module axi_port_arbiter
  import c2a_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  // master 0
  input  axi_aw_t m0_aw_i,
  input  logic    m0_aw_valid_i,
  output logic    m0_aw_ready_o,
  input  axi_w_t  m0_w_i,
  input  logic    m0_w_valid_i,
  output logic    m0_w_ready_o,
  input  axi_ar_t m0_ar_i,
  input  logic    m0_ar_valid_i,
  output logic    m0_ar_ready_o,
  output axi_b_t  m0_b_o,
  output logic    m0_b_valid_o,
  input  logic    m0_b_ready_i,
  output axi_r_t  m0_r_o,
  output logic    m0_r_valid_o,
  input  logic    m0_r_ready_i,
  // master 1
  input  axi_aw_t m1_aw_i,
  input  logic    m1_aw_valid_i,
  output logic    m1_aw_ready_o,
  input  axi_w_t  m1_w_i,
  input  logic    m1_w_valid_i,
  output logic    m1_w_ready_o,
  input  axi_ar_t m1_ar_i,
  input  logic    m1_ar_valid_i,
  output logic    m1_ar_ready_o,
  output axi_b_t  m1_b_o,
  output logic    m1_b_valid_o,
  input  logic    m1_b_ready_i,
  output axi_r_t  m1_r_o,
  output logic    m1_r_valid_o,
  input  logic    m1_r_ready_i,
  // shared port
  output axi_aw_t s_aw_o,
  output logic    s_aw_valid_o,
  input  logic    s_aw_ready_i,
  output axi_w_t  s_w_o,
  output logic    s_w_valid_o,
  input  logic    s_w_ready_i,
  output axi_ar_t s_ar_o,
  output logic    s_ar_valid_o,
  input  logic    s_ar_ready_i,
  input  axi_b_t  s_b_i,
  input  logic    s_b_valid_i,
  output logic    s_b_ready_o,
  input  axi_r_t  s_r_i,
  input  logic    s_r_valid_i,
  output logic    s_r_ready_o
);

  localparam int unsigned IDW = `C2A_AXI_ID_WIDTH;

  // read side: priority, hold flag, held winner
  logic rd_prio_q, rd_hold_q, rd_sel_q, rd_sel;
  // write side: priority, lock, held winner, channels already passed
  logic wr_prio_q, wr_lock_q, wr_sel_q, wr_sel;
  logic aw_done_q, w_done_q, aw_fin, w_fin;
  logic b_port, r_port;

  axi_ar_t ar_mux;
  axi_aw_t aw_mux;

  // replace the id msb with a port index
  function automatic axi_id_t tag_id(input logic port, input axi_id_t id);
    tag_id = {port, id[IDW-2:0]};
  endfunction

  // ------------------------------
  // read address
  // ------------------------------
  always_comb begin
    if (rd_hold_q) begin
      rd_sel = rd_sel_q;
    end else if (m0_ar_valid_i && m1_ar_valid_i) begin
      rd_sel = rd_prio_q;
    end else begin
      rd_sel = m1_ar_valid_i;
    end
  end

  assign ar_mux        = rd_sel ? m1_ar_i : m0_ar_i;
  assign s_ar_o        = '{id: tag_id(rd_sel, ar_mux.id), addr: ar_mux.addr, size: ar_mux.size};
  assign s_ar_valid_o  = rd_sel ? m1_ar_valid_i : m0_ar_valid_i;
  assign m0_ar_ready_o = s_ar_ready_i & ~rd_sel;
  assign m1_ar_ready_o = s_ar_ready_i & rd_sel;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_prio_q <= 1'b0;
      rd_hold_q <= 1'b0;
      rd_sel_q  <= 1'b0;
    end else if (s_ar_valid_o) begin
      if (s_ar_ready_i) begin
        // accepted, the other master goes first next time
        rd_hold_q <= 1'b0;
        rd_prio_q <= ~rd_sel;
      end else begin
        rd_hold_q <= 1'b1;
        rd_sel_q  <= rd_sel;
      end
    end
  end

  // ------------------------------
  // write address and data
  // ------------------------------
  always_comb begin
    if (wr_lock_q) begin
      wr_sel = wr_sel_q;
    end else if ((m0_aw_valid_i | m0_w_valid_i) && (m1_aw_valid_i | m1_w_valid_i)) begin
      wr_sel = wr_prio_q;
    end else begin
      wr_sel = m1_aw_valid_i | m1_w_valid_i;
    end
  end

  assign aw_mux = wr_sel ? m1_aw_i : m0_aw_i;
  assign s_aw_o = '{id: tag_id(wr_sel, aw_mux.id), addr: aw_mux.addr, size: aw_mux.size};
  assign s_w_o  = wr_sel ? m1_w_i : m0_w_i;

  // a channel that already passed stays masked until the lock drops
  assign s_aw_valid_o  = (wr_sel ? m1_aw_valid_i : m0_aw_valid_i) & ~aw_done_q;
  assign s_w_valid_o   = (wr_sel ? m1_w_valid_i : m0_w_valid_i) & ~w_done_q;
  assign m0_aw_ready_o = s_aw_ready_i & ~aw_done_q & ~wr_sel;
  assign m1_aw_ready_o = s_aw_ready_i & ~aw_done_q & wr_sel;
  assign m0_w_ready_o  = s_w_ready_i & ~w_done_q & ~wr_sel;
  assign m1_w_ready_o  = s_w_ready_i & ~w_done_q & wr_sel;

  assign aw_fin = aw_done_q | (s_aw_valid_o & s_aw_ready_i);
  assign w_fin  = w_done_q | (s_w_valid_o & s_w_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_prio_q <= 1'b0;
      wr_lock_q <= 1'b0;
      wr_sel_q  <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else if (s_aw_valid_o || s_w_valid_o) begin
      if (aw_fin && w_fin) begin
        // both halves through, release and rotate
        wr_lock_q <= 1'b0;
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
        wr_prio_q <= ~wr_sel;
      end else begin
        wr_lock_q <= 1'b1;
        wr_sel_q  <= wr_sel;
        aw_done_q <= aw_fin;
        w_done_q  <= w_fin;
      end
    end
  end

  // ------------------------------
  // response routing by id msb
  // ------------------------------
  assign b_port       = s_b_i.id[IDW-1];
  assign m0_b_o       = '{id: tag_id(1'b0, s_b_i.id), resp: s_b_i.resp};
  assign m1_b_o       = '{id: tag_id(1'b0, s_b_i.id), resp: s_b_i.resp};
  assign m0_b_valid_o = s_b_valid_i & ~b_port;
  assign m1_b_valid_o = s_b_valid_i & b_port;
  assign s_b_ready_o  = b_port ? m1_b_ready_i : m0_b_ready_i;

  assign r_port       = s_r_i.id[IDW-1];
  assign m0_r_o       = '{id: tag_id(1'b0, s_r_i.id), data: s_r_i.data,
                          resp: s_r_i.resp, last: s_r_i.last};
  assign m1_r_o       = m0_r_o;
  assign m0_r_valid_o = s_r_valid_i & ~r_port;
  assign m1_r_valid_o = s_r_valid_i & r_port;
  assign s_r_ready_o  = r_port ? m1_r_ready_i : m0_r_ready_i;

endmodule

// File: src/core_axi_subsys.sv
// top level of the core to AXI subsystem
// instruction and data bridges side by side
// arbiter merging both onto one AXI4 master port

`timescale 1ns/10ps

module core_axi_subsys
  import c2a_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // instruction fetch port
  input  logic      if_req_i,
  input  core_req_t if_req_data_i,
  output logic      if_gnt_o,
  output logic      if_rvalid_o,
  output core_rsp_t if_rsp_o,
  // data port
  input  logic      data_req_i,
  input  core_req_t data_req_data_i,
  output logic      data_gnt_o,
  output logic      data_rvalid_o,
  output core_rsp_t data_rsp_o,
  // axi master port
  output axi_aw_t   axi_aw_o,
  output logic      axi_aw_valid_o,
  input  logic      axi_aw_ready_i,
  output axi_w_t    axi_w_o,
  output logic      axi_w_valid_o,
  input  logic      axi_w_ready_i,
  output axi_ar_t   axi_ar_o,
  output logic      axi_ar_valid_o,
  input  logic      axi_ar_ready_i,
  input  axi_b_t    axi_b_i,
  input  logic      axi_b_valid_i,
  output logic      axi_b_ready_o,
  input  axi_r_t    axi_r_i,
  input  logic      axi_r_valid_i,
  output logic      axi_r_ready_o
);

  // ------------------------------
  // bridge to arbiter channels
  // ------------------------------
  axi_aw_t if_aw, data_aw;
  logic    if_aw_valid, if_aw_ready, data_aw_valid, data_aw_ready;
  axi_w_t  if_w, data_w;
  logic    if_w_valid, if_w_ready, data_w_valid, data_w_ready;
  axi_ar_t if_ar, data_ar;
  logic    if_ar_valid, if_ar_ready, data_ar_valid, data_ar_ready;
  axi_b_t  if_b, data_b;
  logic    if_b_valid, if_b_ready, data_b_valid, data_b_ready;
  axi_r_t  if_r, data_r;
  logic    if_r_valid, if_r_ready, data_r_valid, data_r_ready;

  // instruction side, master 0
  core2axi_bridge #(
    .AXI_ID(axi_id_t'(0))
  ) u_if_bridge (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .req_i(if_req_i), .core_req_i(if_req_data_i), .gnt_o(if_gnt_o),
    .rvalid_o(if_rvalid_o), .core_rsp_o(if_rsp_o),
    .aw_o(if_aw), .aw_valid_o(if_aw_valid), .aw_ready_i(if_aw_ready),
    .w_o(if_w), .w_valid_o(if_w_valid), .w_ready_i(if_w_ready),
    .b_i(if_b), .b_valid_i(if_b_valid), .b_ready_o(if_b_ready),
    .ar_o(if_ar), .ar_valid_o(if_ar_valid), .ar_ready_i(if_ar_ready),
    .r_i(if_r), .r_valid_i(if_r_valid), .r_ready_o(if_r_ready)
  );

  // data side, master 1
  core2axi_bridge #(
    .AXI_ID(axi_id_t'(1))
  ) u_data_bridge (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .req_i(data_req_i), .core_req_i(data_req_data_i), .gnt_o(data_gnt_o),
    .rvalid_o(data_rvalid_o), .core_rsp_o(data_rsp_o),
    .aw_o(data_aw), .aw_valid_o(data_aw_valid), .aw_ready_i(data_aw_ready),
    .w_o(data_w), .w_valid_o(data_w_valid), .w_ready_i(data_w_ready),
    .b_i(data_b), .b_valid_i(data_b_valid), .b_ready_o(data_b_ready),
    .ar_o(data_ar), .ar_valid_o(data_ar_valid), .ar_ready_i(data_ar_ready),
    .r_i(data_r), .r_valid_i(data_r_valid), .r_ready_o(data_r_ready)
  );

  axi_port_arbiter u_arbiter (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .m0_aw_i(if_aw), .m0_aw_valid_i(if_aw_valid), .m0_aw_ready_o(if_aw_ready),
    .m0_w_i(if_w), .m0_w_valid_i(if_w_valid), .m0_w_ready_o(if_w_ready),
    .m0_ar_i(if_ar), .m0_ar_valid_i(if_ar_valid), .m0_ar_ready_o(if_ar_ready),
    .m0_b_o(if_b), .m0_b_valid_o(if_b_valid), .m0_b_ready_i(if_b_ready),
    .m0_r_o(if_r), .m0_r_valid_o(if_r_valid), .m0_r_ready_i(if_r_ready),
    .m1_aw_i(data_aw), .m1_aw_valid_i(data_aw_valid), .m1_aw_ready_o(data_aw_ready),
    .m1_w_i(data_w), .m1_w_valid_i(data_w_valid), .m1_w_ready_o(data_w_ready),
    .m1_ar_i(data_ar), .m1_ar_valid_i(data_ar_valid), .m1_ar_ready_o(data_ar_ready),
    .m1_b_o(data_b), .m1_b_valid_o(data_b_valid), .m1_b_ready_i(data_b_ready),
    .m1_r_o(data_r), .m1_r_valid_o(data_r_valid), .m1_r_ready_i(data_r_ready),
    .s_aw_o(axi_aw_o), .s_aw_valid_o(axi_aw_valid_o), .s_aw_ready_i(axi_aw_ready_i),
    .s_w_o(axi_w_o), .s_w_valid_o(axi_w_valid_o), .s_w_ready_i(axi_w_ready_i),
    .s_ar_o(axi_ar_o), .s_ar_valid_o(axi_ar_valid_o), .s_ar_ready_i(axi_ar_ready_i),
    .s_b_i(axi_b_i), .s_b_valid_i(axi_b_valid_i), .s_b_ready_o(axi_b_ready_o),
    .s_r_i(axi_r_i), .s_r_valid_i(axi_r_valid_i), .s_r_ready_o(axi_r_ready_o)
  );

endmodule

// File: dv/axi_mem_model.sv
// AXI slave model for the subsystem testbench
// byte memory with address-dependent fill, one read and one write in flight
// random ready delays of 0 to 3 cycles, response delay of 1 to 4 cycles
// addresses at or above the memory size answer SLVERR

`timescale 1ns/10ps

`include "c2a_cfg.svh"

module axi_mem_model
  import c2a_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  axi_aw_t aw_i,
  input  logic    aw_valid_i,
  output logic    aw_ready_o,
  input  axi_w_t  w_i,
  input  logic    w_valid_i,
  output logic    w_ready_o,
  input  axi_ar_t ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  output axi_b_t  b_o,
  output logic    b_valid_o,
  input  logic    b_ready_i,
  output axi_r_t  r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i
);

  localparam int unsigned MEM_BYTES = `C2A_MEM_BYTES;
  localparam int unsigned BUS_BYTES = `C2A_AXI_DATA_WIDTH / 8;

  logic [7:0] mem [0:MEM_BYTES-1];

  // every address bit feeds the pattern
  function automatic logic [7:0] fill_byte(input logic [11:0] a);
    fill_byte = a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h3c;
  endfunction

  function automatic logic in_range(input addr_t a);
    in_range = a < addr_t'(MEM_BYTES);
  endfunction

  // whole bus beat around the address
  function automatic axi_data_t read_beat(input addr_t a);
    axi_data_t d;
    addr_t     base;
    d    = '0;
    base = a & ~addr_t'(BUS_BYTES - 1);
    for (int i = 0; i < BUS_BYTES; i++) begin
      d[i*8 +: 8] = mem[base[11:0] + 12'(i)];
    end
    return d;
  endfunction

  initial begin
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i] = fill_byte(12'(i));
    end
  end

  // ------------------------------
  // read channel
  // ------------------------------
  initial begin : read_channel
    axi_ar_t     ar_q;
    int unsigned wait_n;
    logic        taken;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_o        = '0;
    ar_q       = '0;
    wait (rst_ni == 1'b1);
    forever begin
      wait_n = $urandom_range(0, 3);
      taken  = 1'b0;
      while (!taken) begin
        @(negedge clk_i);
        ar_ready_o = (wait_n == 0);
        if (wait_n != 0) wait_n--;
        @(posedge clk_i);
        if (ar_ready_o && ar_valid_i) begin
          taken = 1'b1;
          ar_q  = ar_i;
        end
      end
      @(negedge clk_i);
      ar_ready_o = 1'b0;
      // data taken at address acceptance
      if (in_range(ar_q.addr)) begin
        r_o = '{id: ar_q.id, data: read_beat(ar_q.addr), resp: RESP_OKAY, last: 1'b1};
      end else begin
        r_o = '{id: ar_q.id, data: '0, resp: RESP_SLVERR, last: 1'b1};
      end
      repeat ($urandom_range(1, 4) - 1) @(negedge clk_i);
      r_valid_o = 1'b1;
      do @(posedge clk_i); while (!r_ready_i);
      @(negedge clk_i);
      r_valid_o = 1'b0;
    end
  end

  // ------------------------------
  // write channels
  // ------------------------------
  initial begin : write_channel
    axi_aw_t     aw_q;
    axi_w_t      w_q;
    int unsigned aw_n;
    int unsigned w_n;
    logic        aw_seen;
    logic        w_seen;
    addr_t       base;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    b_valid_o  = 1'b0;
    b_o        = '0;
    aw_q       = '0;
    w_q        = '0;
    wait (rst_ni == 1'b1);
    forever begin
      aw_n    = $urandom_range(0, 3);
      w_n     = $urandom_range(0, 3);
      aw_seen = 1'b0;
      w_seen  = 1'b0;
      // AW and W accepted independently, W may come first
      while (!(aw_seen && w_seen)) begin
        @(negedge clk_i);
        aw_ready_o = !aw_seen && (aw_n == 0);
        w_ready_o  = !w_seen && (w_n == 0);
        if (aw_n != 0) aw_n--;
        if (w_n != 0) w_n--;
        @(posedge clk_i);
        if (aw_ready_o && aw_valid_i) begin
          aw_seen = 1'b1;
          aw_q    = aw_i;
        end
        if (w_ready_o && w_valid_i) begin
          w_seen = 1'b1;
          w_q    = w_i;
        end
      end
      @(negedge clk_i);
      aw_ready_o = 1'b0;
      w_ready_o  = 1'b0;
      if (in_range(aw_q.addr)) begin
        base = aw_q.addr & ~addr_t'(BUS_BYTES - 1);
        for (int i = 0; i < BUS_BYTES; i++) begin
          if (w_q.strb[i]) mem[base[11:0] + 12'(i)] = w_q.data[i*8 +: 8];
        end
        b_o = '{id: aw_q.id, resp: RESP_OKAY};
      end else begin
        b_o = '{id: aw_q.id, resp: RESP_SLVERR};
      end
      repeat ($urandom_range(1, 4) - 1) @(negedge clk_i);
      b_valid_o = 1'b1;
      do @(posedge clk_i); while (!b_ready_i);
      @(negedge clk_i);
      b_valid_o = 1'b0;
    end
  end

endmodule

// File: dv/tb_core_axi_subsys.sv
// testbench top for the core to AXI subsystem
// clock, reset, port drivers, reference memory, response comparator
// id, size and write beat checks on the shared port, watchdog and summary

`timescale 1ns/10ps

`include "c2a_cfg.svh"

module tb_core_axi_subsys
  import c2a_pkg::*;
;

  localparam int unsigned MEM_BYTES = `C2A_MEM_BYTES;
  localparam int          NUM_RAND  = 150;
  // scripted plus random transactions over both ports
  localparam int          TOTAL_TXN = 2 * NUM_RAND + 20;

  typedef struct packed {
    word_t data;
    logic  err;
    logic  is_read;
  } exp_t;

  logic      clk;
  logic      rst_n;
  logic      if_req, data_req;
  core_req_t if_req_data, data_req_data;
  logic      if_gnt, if_rvalid, data_gnt, data_rvalid;
  core_rsp_t if_rsp, data_rsp;

  axi_aw_t axi_aw;
  axi_w_t  axi_w;
  axi_ar_t axi_ar;
  axi_b_t  axi_b;
  axi_r_t  axi_r;
  logic    axi_aw_valid, axi_aw_ready, axi_w_valid, axi_w_ready;
  logic    axi_ar_valid, axi_ar_ready, axi_b_valid, axi_b_ready;
  logic    axi_r_valid, axi_r_ready;

  logic [7:0] ref_mem [0:MEM_BYTES-1];
  exp_t       exp_q0[$];
  exp_t       exp_q1[$];
  int         req_cnt [2];
  int         rsp_cnt [2];
  int         errors;

  core_axi_subsys u_core_axi_subsys (
    .clk_i(clk), .rst_ni(rst_n),
    .if_req_i(if_req), .if_req_data_i(if_req_data), .if_gnt_o(if_gnt),
    .if_rvalid_o(if_rvalid), .if_rsp_o(if_rsp),
    .data_req_i(data_req), .data_req_data_i(data_req_data), .data_gnt_o(data_gnt),
    .data_rvalid_o(data_rvalid), .data_rsp_o(data_rsp),
    .axi_aw_o(axi_aw), .axi_aw_valid_o(axi_aw_valid), .axi_aw_ready_i(axi_aw_ready),
    .axi_w_o(axi_w), .axi_w_valid_o(axi_w_valid), .axi_w_ready_i(axi_w_ready),
    .axi_ar_o(axi_ar), .axi_ar_valid_o(axi_ar_valid), .axi_ar_ready_i(axi_ar_ready),
    .axi_b_i(axi_b), .axi_b_valid_i(axi_b_valid), .axi_b_ready_o(axi_b_ready),
    .axi_r_i(axi_r), .axi_r_valid_i(axi_r_valid), .axi_r_ready_o(axi_r_ready)
  );

  axi_mem_model u_mem (
    .clk_i(clk), .rst_ni(rst_n),
    .aw_i(axi_aw), .aw_valid_i(axi_aw_valid), .aw_ready_o(axi_aw_ready),
    .w_i(axi_w), .w_valid_i(axi_w_valid), .w_ready_o(axi_w_ready),
    .ar_i(axi_ar), .ar_valid_i(axi_ar_valid), .ar_ready_o(axi_ar_ready),
    .b_o(axi_b), .b_valid_o(axi_b_valid), .b_ready_i(axi_b_ready),
    .r_o(axi_r), .r_valid_o(axi_r_valid), .r_ready_i(axi_r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic logic [7:0] fill_byte(input logic [11:0] a);
    fill_byte = a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h3c;
  endfunction

  // byte memory where enabled bytes are written and reads return the aligned word
  function automatic exp_t ref_access(input core_req_t rq);
    exp_t  e;
    addr_t wa;
    e.is_read = !rq.we;
    e.err     = rq.addr >= addr_t'(MEM_BYTES);
    e.data    = '0;
    wa        = {rq.addr[31:2], 2'b00};
    if (!e.err) begin
      for (int i = 0; i < 4; i++) begin
        if (rq.we && rq.be[i]) ref_mem[wa[11:0] + 12'(i)] = rq.wdata[i*8 +: 8];
        if (!rq.we) e.data[i*8 +: 8] = ref_mem[wa[11:0] + 12'(i)];
      end
    end
    return e;
  endfunction

  // ------------------------------
  // port driver
  // ------------------------------
  task automatic issue(input int port, input addr_t addr, input logic we,
                       input be_t be, input word_t wdata);
    core_req_t rq;
    logic      flag;
    rq = '{addr: addr, we: we, be: be, wdata: wdata};
    @(negedge clk);
    if (port == 0) begin
      if_req      = 1'b1;
      if_req_data = rq;
    end else begin
      data_req      = 1'b1;
      data_req_data = rq;
    end
    // payload held until grant
    flag = 1'b0;
    while (!flag) begin
      @(posedge clk);
      flag = (port == 0) ? if_gnt : data_gnt;
    end
    req_cnt[port]++;
    if (port == 0) exp_q0.push_back(ref_access(rq));
    else exp_q1.push_back(ref_access(rq));
    @(negedge clk);
    if (port == 0) if_req = 1'b0;
    else data_req = 1'b0;
    // no new request before rvalid
    flag = 1'b0;
    while (!flag) begin
      @(posedge clk);
      flag = (port == 0) ? if_rvalid : data_rvalid;
    end
  endtask

  // port 0 stays below 0x800, port 1 above, a few go to the error region
  task automatic random_traffic(input int port, input int n);
    addr_t a;
    for (int k = 0; k < n; k++) begin
      if ($urandom_range(0, 15) == 0) begin
        a = addr_t'(MEM_BYTES) + (addr_t'($urandom_range(0, 1023)) << 2);
      end else begin
        a = addr_t'(port * 32'h800) + (addr_t'($urandom_range(0, 511)) << 2);
      end
      issue(port, a, 1'($urandom_range(0, 1)), be_t'($urandom_range(1, 15)), $urandom());
      repeat ($urandom_range(0, 2)) @(negedge clk);
    end
  endtask

  // ------------------------------
  // comparator
  // ------------------------------
  task automatic check_rsp(input int port, input core_rsp_t rsp);
    exp_t  e;
    string nm;
    nm = (port == 0) ? "if_rsp_o" : "data_rsp_o";
    // every rvalid pulse counts, expected or not
    rsp_cnt[port]++;
    if ((port == 0 && exp_q0.size() == 0) || (port == 1 && exp_q1.size() == 0)) begin
      $display("%s: rvalid seen with no request outstanding", nm);
      errors++;
    end else begin
      e = (port == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
      if (rsp.err !== e.err) begin
        $display("mismatch %s.err: got %h expected %h", nm, rsp.err, e.err);
        errors++;
      end
      if (e.is_read && !e.err && rsp.rdata !== e.data) begin
        $display("mismatch %s.rdata: got %h expected %h", nm, rsp.rdata, e.data);
        errors++;
      end
    end
  endtask

  // instruction port tags as 0, data port as 8 plus its own id 1
  task automatic check_tag(input string nm, input axi_id_t id);
    if (id !== 4'h0 && id !== 4'h9) begin
      $display("mismatch %s: got %h expected 0 or 9", nm, id);
      errors++;
    end
  endtask

  // every access moves one 4-byte word
  task automatic check_size(input string nm, input logic [2:0] size);
    if (size !== 3'h2) begin
      $display("mismatch %s: got %h expected 2", nm, size);
      errors++;
    end
  endtask

  // single beat with the core word on both halves
  task automatic check_w(input axi_w_t w);
    if (w.last !== 1'b1) begin
      $display("mismatch axi_w_o.last: got %h expected 1", w.last);
      errors++;
    end
    if (w.data[63:32] !== w.data[31:0]) begin
      $display("mismatch axi_w_o.data: got %h expected %h", w.data,
               {w.data[31:0], w.data[31:0]});
      errors++;
    end
    // strobes live in one half only
    if (w.strb[7:4] != 4'h0 && w.strb[3:0] != 4'h0) begin
      $display("mismatch axi_w_o.strb: got %h expected one half zero", w.strb);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      if (if_rvalid) check_rsp(0, if_rsp);
      if (data_rvalid) check_rsp(1, data_rsp);
      if (axi_ar_valid && axi_ar_ready) begin
        check_tag("axi_ar_o.id", axi_ar.id);
        check_size("axi_ar_o.size", axi_ar.size);
      end
      if (axi_aw_valid && axi_aw_ready) begin
        check_tag("axi_aw_o.id", axi_aw.id);
        check_size("axi_aw_o.size", axi_aw.size);
      end
      if (axi_w_valid && axi_w_ready) check_w(axi_w);
    end
  end

  // ------------------------------
  // watchdog
  // ------------------------------
  initial begin
    repeat (TOTAL_TXN * 20 + 200) @(posedge clk);
    $display("timeout: transactions did not finish in time, errors so far %0d", errors);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    void'($urandom(32'hac29_40a4));
    errors        = 0;
    req_cnt       = '{0, 0};
    rsp_cnt       = '{0, 0};
    if_req        = 1'b0;
    if_req_data   = '0;
    data_req      = 1'b0;
    data_req_data = '0;
    rst_n         = 1'b0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      ref_mem[i] = fill_byte(12'(i));
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // idle outputs stay low before any request
    repeat (3) begin
      @(posedge clk);
      if ({if_gnt, if_rvalid, data_gnt, data_rvalid,
           axi_aw_valid, axi_w_valid, axi_ar_valid} !== 7'h0) begin
        $display("mismatch idle outputs: got %h expected 00",
                 {if_gnt, if_rvalid, data_gnt, data_rvalid,
                  axi_aw_valid, axi_w_valid, axi_ar_valid});
        errors++;
      end
    end

    // write then read back on both bus halves
    issue(1, 32'h100, 1'b1, 4'hf, 32'hdead_beef);
    issue(1, 32'h100, 1'b0, 4'hf, '0);
    issue(0, 32'h100, 1'b0, 4'hf, '0);
    issue(1, 32'h104, 1'b1, 4'hf, 32'h1234_5678);
    issue(1, 32'h104, 1'b0, 4'hf, '0);
    issue(0, 32'h104, 1'b0, 4'hf, '0);

    // partial byte enables merge with old contents
    issue(1, 32'h100, 1'b1, 4'b0101, 32'ha5a5_a5a5);
    issue(0, 32'h100, 1'b0, 4'hf, '0);
    issue(1, 32'h104, 1'b1, 4'b1100, 32'h0f0f_0f0f);
    issue(1, 32'h104, 1'b0, 4'hf, '0);

    // error region write must not land on the word it would alias to
    issue(1, 32'h1000, 1'b1, 4'hf, 32'h5555_aaaa);
    issue(1, 32'h1000, 1'b0, 4'hf, '0);
    issue(0, 32'h2000_0104, 1'b0, 4'hf, '0);
    issue(1, 32'h000, 1'b0, 4'hf, '0);

    // both ports at once
    fork
      issue(0, 32'h104, 1'b0, 4'hf, '0);
      issue(1, 32'h900, 1'b1, 4'hf, 32'hcafe_f00d);
    join
    fork
      issue(0, 32'h10c, 1'b1, 4'b0011, 32'h0bad_1dea);
      issue(1, 32'h900, 1'b0, 4'hf, '0);
    join
    fork
      issue(0, 32'h10c, 1'b0, 4'hf, '0);
      issue(1, 32'h904, 1'b0, 4'hf, '0);
    join

    // long random run with back-pressure from the memory model
    fork
      random_traffic(0, NUM_RAND);
      random_traffic(1, NUM_RAND);
    join
    repeat (4) @(negedge clk);

    for (int p = 0; p < 2; p++) begin
      if (req_cnt[p] != rsp_cnt[p]) begin
        $display("port %0d: %0d grants but %0d responses", p, req_cnt[p], rsp_cnt[p]);
        errors++;
      end
    end

    $display("errors %0d, if port %0d/%0d req/rsp, data port %0d/%0d req/rsp",
             errors, req_cnt[0], rsp_cnt[0], req_cnt[1], rsp_cnt[1]);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+include
src/c2a_pkg.sv
src/core2axi_bridge.sv
src/axi_port_arbiter.sv
src/core_axi_subsys.sv
dv/axi_mem_model.sv
dv/tb_core_axi_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_core_axi_subsys

verilator --binary --timing -j 0 \
  -f build.f \
  --top-module "${TOP}" \
  -o "${TOP}_sim"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"${TOP}_sim" > "${LOG}" 2>&1
status=$?
cat "${LOG}"
if [ ${status} -ne 0 ]; then
  echo "simulation exited with status ${status}"
  exit 1
fi

if grep -qF "*** TEST FAILED ***" "${LOG}"; then
  echo "failure reported in ${LOG}"
  exit 1
fi

if ! grep -qF "*** TEST PASSED ***" "${LOG}"; then
  echo "no pass line found in ${LOG}"
  exit 1
fi

exit 0
